// ==== verilog.f ====
design/cpu_pkg.sv
design/icache_mem.sv
design/icache.sv
design/fetch_stage.sv
design/decode_stage.sv
design/rob.sv
design/alu_stage.sv
design/processor.sv
testbench/clock_gen.sv
testbench/tb_processor.sv

// ==== Makefile ====
# Verilator build and run of the processor testbench
VERILATOR ?= verilator
TOP       ?= tb_processor
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/processor_testdata.mem ====
// program images, a header and expected commit records for tb_processor
// record columns: dest register, result data, next pc, write flag
@00
// program a: every alu op, addi and lui, dependent chains, x0 write, then wfi
00500093 00708113 002081b3 40118233
123452b7 fff28293 0032f333 004363b3
0053c433 00140013 401004b3 00948533
10500073
@20
// program b: sll is outside the subset and sits ahead of the wfi
abcde0b7 12308113 001141b3 00209233
10500073
@40
// header: commits of a, final status of a, commits of b, final status of b
0000000c 00000002 00000003 00000001
@44
// records of program a
00000001 00000005 00000004 00000001
00000002 0000000c 00000008 00000001
00000003 00000011 0000000c 00000001
00000004 0000000c 00000010 00000001
00000005 12345000 00000014 00000001
00000005 12344fff 00000018 00000001
00000006 00000011 0000001c 00000001
00000007 0000001d 00000020 00000001
00000008 12344fe2 00000024 00000001
00000000 12344fe3 00000028 00000000
00000009 fffffffb 0000002c 00000001
0000000a fffffff6 00000030 00000001
// records of program b
00000001 abcde000 00000004 00000001
00000002 abcde123 00000008 00000001
00000003 00000123 0000000c 00000001

// ==== testbench/tb_processor.sv ====
// top-level testbench that runs both programs of the data file through the processor and checks every commit
`timescale 1ns/1ns

module tb_processor;

	// word offsets inside the data file
	localparam int         sect_words   = 32;
	localparam logic [7:0] hdr_base     = 8'h40;
	localparam logic [7:0] record_base  = 8'h44;
	localparam int         quiet_cycles = 16;

	logic                             clock;
	logic                             rst_n;
	logic                             reset_req;
	logic [cpu_pkg::tag_bits-1:0]     mem_response;
	logic [cpu_pkg::tag_bits-1:0]     mem_tag;
	logic [cpu_pkg::line_bits-1:0]    mem_data;
	cpu_pkg::bus_cmd_e                mem_command;
	logic [cpu_pkg::xlen-1:0]         mem_addr;
	logic                             commit_valid;
	logic                             commit_wr_en;
	logic [cpu_pkg::reg_idx_bits-1:0] commit_wr_idx;
	logic [cpu_pkg::xlen-1:0]         commit_wr_data;
	logic [cpu_pkg::xlen-1:0]         commit_npc;
	cpu_pkg::error_status_e           error_status;

	// file image, memory model and bookkeeping
	logic [31:0]                  testdata_mem [0:255];
	bit                           line_seen [bit [31:0]];
	logic [31:0]                  lfsr;
	logic [cpu_pkg::tag_bits-1:0] next_tag;
	logic [cpu_pkg::tag_bits-1:0] pend_tag;
	logic [31:0]                  pend_addr;
	logic                         pending;
	int                           wait_left;
	int                           section;
	int                           failures;
	int                           cycle_count;
	int                           cycle_limit;
	int                           count_a;
	int                           count_b;
	int                           fill_i;
	logic [1:0]                   status_a;
	logic [1:0]                   status_b;

	clock_gen #(
		.half_period (2),
		.reset_cycles(2)
	) clock_gen0 (
		.reset_req(reset_req),
		.clock    (clock),
		.rst_n    (rst_n)
	);

	processor dut0 (
		.clock         (clock),
		.rst_n         (rst_n),
		.mem_response  (mem_response),
		.mem_tag       (mem_tag),
		.mem_data      (mem_data),
		.mem_command   (mem_command),
		.mem_addr      (mem_addr),
		.commit_valid  (commit_valid),
		.commit_wr_en  (commit_wr_en),
		.commit_wr_idx (commit_wr_idx),
		.commit_wr_data(commit_wr_data),
		.commit_npc    (commit_npc),
		.error_status  (error_status)
	);

	////////////////////////////////////////////////////////////
	// failure reporting
	////////////////////////////////////////////////////////////

	task finish_failed;
		$display("Test FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task fail_value(input string msg);
		failures++;
		$display("[FAIL] %0t ns: %s", $time, msg);
		finish_failed();
	endtask

	////////////////////////////////////////////////////////////
	// memory model
	////////////////////////////////////////////////////////////

	// galois lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// latency of 2 to 9 cycles from three single-step bits
	task automatic draw_latency(output int cycles);
		logic [2:0] bits;
		bits = '0;
		for (int i = 0; i < 3; i++) begin
			bits = {bits[1:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		cycles = 2 + int'(bits);
	endtask

	// words nobody loaded
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
	endfunction

	function automatic logic [31:0] prog_word(input logic [31:0] w);
		logic [7:0] idx;
		idx = 8'(section * sect_words) + w[7:0];
		if (w < 32'(sect_words)) return testdata_mem[idx];
		return fill_word(w);
	endfunction

	// upper word at pc bit 2 set
	function automatic logic [cpu_pkg::line_bits-1:0] line_image(input logic [31:0] addr);
		logic [31:0] w;
		w = {2'b00, addr[31:2]};
		return {prog_word(w + 32'd1), prog_word(w)};
	endfunction

	always @(posedge clock) begin
		#1;
		if (!rst_n) begin
			mem_response = '0;
			mem_tag      = '0;
			mem_data     = '0;
			pending      = 1'b0;
			line_seen.delete();
		end else begin
			mem_tag  = '0;
			mem_data = '0;
			// data only in its own cycle
			if (pending) begin
				if (wait_left <= 1) begin
					mem_tag  = pend_tag;
					mem_data = line_image(pend_addr);
					pending  = 1'b0;
				end else begin
					wait_left = wait_left - 1;
				end
			end
			mem_response = '0;
			if (mem_command == cpu_pkg::bus_load) begin
				assert (mem_addr[2:0] == 3'b000)
				else fail_value($sformatf("mem_addr %h is not line aligned", mem_addr));
				assert (!line_seen.exists(mem_addr))
				else fail_value($sformatf("line %h requested a second time", mem_addr));
				assert (!pending)
				else fail_value("a second fill was requested while one was outstanding");
				line_seen[mem_addr] = 1'b1;
				// every request accepted with tags rotating over 1..15
				mem_response = next_tag;
				pend_tag     = next_tag;
				pend_addr    = mem_addr;
				pending      = 1'b1;
				draw_latency(wait_left);
				next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// reset values during reset and in the first cycle after release
	task check_reset_phase;
		do begin
			@(negedge clock);
			assert (!commit_valid) else fail_value("commit_valid high around reset");
			assert (!commit_wr_en) else fail_value("commit_wr_en high around reset");
			assert (mem_command == cpu_pkg::bus_none)
			else fail_value("memory command issued around reset");
			assert (error_status == cpu_pkg::no_error)
			else fail_value("error_status not clear around reset");
		end while (!rst_n);
	endtask

	// in-order commits followed by a sticky status and no further commit
	task automatic run_section(input int rec_first, input int n_exp, input logic [1:0] status_exp);
		int         seen;
		int         quiet;
		logic [7:0] rec;
		logic [4:0] exp_idx;
		logic [31:0] exp_data;
		logic [31:0] exp_npc;
		logic        exp_wr;
		seen  = 0;
		quiet = 0;
		while (quiet < quiet_cycles) begin
			@(negedge clock);
			if (commit_valid) begin
				assert (seen < n_exp)
				else fail_value($sformatf("unexpected commit with npc %h", commit_npc));
				rec      = record_base + 8'(4 * (rec_first + seen));
				exp_idx  = testdata_mem[rec][4:0];
				exp_data = testdata_mem[rec + 8'd1];
				exp_npc  = testdata_mem[rec + 8'd2];
				exp_wr   = testdata_mem[rec + 8'd3][0];
				assert (commit_npc == exp_npc)
				else fail_value($sformatf("commit %0d npc %h, expected %h", seen,
					commit_npc, exp_npc));
				assert (commit_wr_en == exp_wr)
				else fail_value($sformatf("commit %0d wr_en %b, expected %b", seen,
					commit_wr_en, exp_wr));
				assert (commit_wr_idx == exp_idx)
				else fail_value($sformatf("commit %0d register x%0d, expected x%0d", seen,
					commit_wr_idx, exp_idx));
				// data only matters for a real write
				if (exp_wr) begin
					assert (commit_wr_data == exp_data)
					else fail_value($sformatf("commit %0d data %h, expected %h", seen,
						commit_wr_data, exp_data));
				end
				seen++;
			end
			if (seen < n_exp) begin
				assert (error_status == cpu_pkg::no_error)
				else fail_value($sformatf("status %0d before all %0d commits", error_status,
					n_exp));
			end else if (error_status != cpu_pkg::no_error) begin
				assert (2'(error_status) == status_exp)
				else fail_value($sformatf("final status %0d, expected %0d", error_status,
					status_exp));
				quiet++;
			end
		end
	endtask

	// bound on the whole run
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			failures++;
			$display("timeout after %0d cycles, the processor never reached its final status",
				cycle_count);
			finish_failed();
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		mem_response = '0;
		mem_tag      = '0;
		mem_data     = '0;
		reset_req    = 1'b0;
		section      = 0;
		failures     = 0;
		cycle_count  = 0;
		cycle_limit  = 0;
		pending      = 1'b0;
		next_tag     = 4'h1;
		lfsr         = 32'h940c7677;
		for (fill_i = 0; fill_i < 256; fill_i++) begin
			testdata_mem[fill_i] = fill_word(32'(fill_i));
		end
		$readmemh("testbench/processor_testdata.mem", testdata_mem);
		count_a     = int'(testdata_mem[hdr_base]);
		status_a    = testdata_mem[hdr_base + 8'd1][1:0];
		count_b     = int'(testdata_mem[hdr_base + 8'd2]);
		status_b    = testdata_mem[hdr_base + 8'd3][1:0];
		cycle_limit = 40 * (count_a + count_b) + 200;

		check_reset_phase();
		run_section(0, count_a, status_a);

		// second image behind a fresh reset
		@(posedge clock);
		#1;
		section   = 1;
		reset_req = 1'b1;
		check_reset_phase();
		reset_req = 1'b0;
		run_section(count_a, count_b, status_b);

		if (failures == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== testbench/clock_gen.sv ====
// testbench clock and reset source, reset also pulses again on each rising reset_req
`timescale 1ns/1ns

module clock_gen #(
	parameter int half_period  = 2,
	parameter int reset_cycles = 2
) (
	input  logic reset_req,
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #(half_period) clock = ~clock;
	end

	// reset low for a few edges, released just after a rising edge
	always begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		#1;
		rst_n = 1'b1;
		@(posedge reset_req);
	end

endmodule

// ==== design/processor.sv ====
// processor top, ties the cache, fetch, decode, alu and rob to the memory and commit ports
`timescale 1ns/1ns

module processor #(
	parameter int rob_depth   = 8,
	parameter int cache_lines = 32
) (
	input  logic                             clock,
	input  logic                             rst_n,
	input  logic [cpu_pkg::tag_bits-1:0]     mem_response,
	input  logic [cpu_pkg::tag_bits-1:0]     mem_tag,
	input  logic [cpu_pkg::line_bits-1:0]    mem_data,
	output cpu_pkg::bus_cmd_e                mem_command,
	output logic [cpu_pkg::xlen-1:0]         mem_addr,
	output logic                             commit_valid,
	output logic                             commit_wr_en,
	output logic [cpu_pkg::reg_idx_bits-1:0] commit_wr_idx,
	output logic [cpu_pkg::xlen-1:0]         commit_wr_data,
	output logic [cpu_pkg::xlen-1:0]         commit_npc,
	output cpu_pkg::error_status_e           error_status
);

	// cache to fetch
	logic [cpu_pkg::xlen-1:0]      fetch_addr;
	logic [cpu_pkg::line_bits-1:0] line_data;
	logic                          line_valid;

	// fetch to decode
	logic [cpu_pkg::xlen-1:0] inst;
	logic [cpu_pkg::xlen-1:0] inst_pc;
	logic                     inst_valid;
	logic                     dispatch_stall;

	// dispatch bundle
	logic                             dispatch_valid;
	logic [cpu_pkg::reg_idx_bits-1:0] disp_dest;
	logic                             disp_wr;
	logic                             disp_illegal;
	logic                             disp_halt;
	logic [cpu_pkg::xlen-1:0]         disp_pc;
	cpu_pkg::alu_op_e                 alu_op;
	logic [cpu_pkg::xlen-1:0]         opa;
	logic [cpu_pkg::xlen-1:0]         opb;
	logic [$clog2(rob_depth)-1:0]     rob_tail;
	logic                             rob_full;

	// cdb
	logic                         cdb_valid;
	logic [$clog2(rob_depth)-1:0] cdb_rob_idx;
	logic [cpu_pkg::xlen-1:0]     cdb_data;

	icache #(
		.cache_lines(cache_lines)
	) icache0 (
		.clock       (clock),
		.rst_n       (rst_n),
		.fetch_addr  (fetch_addr),
		.line_data   (line_data),
		.line_valid  (line_valid),
		.mem_command (mem_command),
		.mem_addr    (mem_addr),
		.mem_response(mem_response),
		.mem_tag     (mem_tag),
		.mem_data    (mem_data)
	);

	fetch_stage fetch0 (
		.clock         (clock),
		.rst_n         (rst_n),
		.line_data     (line_data),
		.line_valid    (line_valid),
		.dispatch_stall(dispatch_stall),
		.fetch_addr    (fetch_addr),
		.inst          (inst),
		.inst_pc       (inst_pc),
		.inst_valid    (inst_valid)
	);

	decode_stage decode0 (
		.clock         (clock),
		.rst_n         (rst_n),
		.inst          (inst),
		.inst_pc       (inst_pc),
		.inst_valid    (inst_valid),
		.dispatch_stall(dispatch_stall),
		.rob_full      (rob_full),
		.dispatch_valid(dispatch_valid),
		.disp_dest     (disp_dest),
		.disp_wr       (disp_wr),
		.disp_illegal  (disp_illegal),
		.disp_halt     (disp_halt),
		.disp_pc       (disp_pc),
		.alu_op        (alu_op),
		.opa           (opa),
		.opb           (opb),
		.commit_wr_en  (commit_wr_en),
		.commit_wr_idx (commit_wr_idx),
		.commit_wr_data(commit_wr_data)
	);

	// result tagged with the slot allocated this cycle
	alu_stage #(
		.rob_depth(rob_depth)
	) alu0 (
		.clock         (clock),
		.rst_n         (rst_n),
		.dispatch_valid(dispatch_valid),
		.alu_op        (alu_op),
		.opa           (opa),
		.opb           (opb),
		.rob_idx       (rob_tail),
		.cdb_valid     (cdb_valid),
		.cdb_rob_idx   (cdb_rob_idx),
		.cdb_data      (cdb_data)
	);

	rob #(
		.rob_depth(rob_depth)
	) rob0 (
		.clock         (clock),
		.rst_n         (rst_n),
		.dispatch_valid(dispatch_valid),
		.disp_wr       (disp_wr),
		.disp_illegal  (disp_illegal),
		.disp_halt     (disp_halt),
		.disp_dest     (disp_dest),
		.disp_pc       (disp_pc),
		.rob_tail      (rob_tail),
		.rob_full      (rob_full),
		.cdb_valid     (cdb_valid),
		.cdb_rob_idx   (cdb_rob_idx),
		.cdb_data      (cdb_data),
		.commit_valid  (commit_valid),
		.commit_wr_en  (commit_wr_en),
		.commit_wr_idx (commit_wr_idx),
		.commit_wr_data(commit_wr_data),
		.commit_npc    (commit_npc),
		.error_status  (error_status)
	);

endmodule

// ==== design/alu_stage.sv ====
// single-cycle alu, puts each dispatched result on the cdb one cycle later
`timescale 1ns/1ns

module alu_stage #(
	parameter int rob_depth = 8
) (
	input  logic                         clock,
	input  logic                         rst_n,
	input  logic                         dispatch_valid,
	input  cpu_pkg::alu_op_e             alu_op,
	input  logic [cpu_pkg::xlen-1:0]     opa,
	input  logic [cpu_pkg::xlen-1:0]     opb,
	input  logic [$clog2(rob_depth)-1:0] rob_idx,
	output logic                         cdb_valid,
	output logic [$clog2(rob_depth)-1:0] cdb_rob_idx,
	output logic [cpu_pkg::xlen-1:0]     cdb_data
);

	logic [cpu_pkg::xlen-1:0] result;

	always_comb begin
		case (alu_op)
			cpu_pkg::op_add: result = opa + opb;
			cpu_pkg::op_sub: result = opa - opb;
			cpu_pkg::op_and: result = opa & opb;
			cpu_pkg::op_or:  result = opa | opb;
			cpu_pkg::op_xor: result = opa ^ opb;
			// upper immediate already shifted by decode
			cpu_pkg::op_lui: result = opb;
			default:         result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) cdb_valid <= 1'b0;
		else cdb_valid <= dispatch_valid;
	end

	// cdb payload
	always_ff @(posedge clock) begin
		if (dispatch_valid) begin
			cdb_rob_idx <= rob_idx;
			cdb_data    <= result;
		end
	end

endmodule

// ==== design/rob.sv ====
// reorder buffer, completes from the cdb and commits one entry per cycle in order
`timescale 1ns/1ns

module rob #(
	parameter int rob_depth = 8
) (
	input  logic                             clock,
	input  logic                             rst_n,
	input  logic                             dispatch_valid,
	input  logic                             disp_wr,
	input  logic                             disp_illegal,
	input  logic                             disp_halt,
	input  logic [cpu_pkg::reg_idx_bits-1:0] disp_dest,
	input  logic [cpu_pkg::xlen-1:0]         disp_pc,
	output logic [$clog2(rob_depth)-1:0]     rob_tail,
	output logic                             rob_full,
	input  logic                             cdb_valid,
	input  logic [$clog2(rob_depth)-1:0]     cdb_rob_idx,
	input  logic [cpu_pkg::xlen-1:0]         cdb_data,
	output logic                             commit_valid,
	output logic                             commit_wr_en,
	output logic [cpu_pkg::reg_idx_bits-1:0] commit_wr_idx,
	output logic [cpu_pkg::xlen-1:0]         commit_wr_data,
	output logic [cpu_pkg::xlen-1:0]         commit_npc,
	output cpu_pkg::error_status_e           error_status
);

	localparam int ptr_bits = $clog2(rob_depth);

	logic [ptr_bits-1:0] head;
	logic [ptr_bits-1:0] tail;
	logic [ptr_bits:0]   count;

	// entry fields
	logic [cpu_pkg::reg_idx_bits-1:0] e_dest [rob_depth];
	logic [cpu_pkg::xlen-1:0]         e_pc [rob_depth];
	logic [cpu_pkg::xlen-1:0]         e_data [rob_depth];
	logic [rob_depth-1:0]             e_wr;
	logic [rob_depth-1:0]             e_illegal;
	logic [rob_depth-1:0]             e_halt;
	logic [rob_depth-1:0]             e_done;

	logic head_ready;
	logic head_error;

	assign rob_tail = tail;
	assign rob_full = (count == (ptr_bits + 1)'(rob_depth));

	////////////////////////////////////////////////////////////
	// head and commit
	////////////////////////////////////////////////////////////

	// nothing leaves once the status went sticky
	assign head_ready = (count != '0) && e_done[head] &&
		(error_status == cpu_pkg::no_error);
	assign head_error = e_illegal[head] | e_halt[head];

	// error entries stop at the head without a commit
	assign commit_valid   = head_ready && !head_error;
	assign commit_wr_en   = commit_valid && e_wr[head];
	assign commit_wr_idx  = e_dest[head];
	assign commit_wr_data = e_data[head];
	assign commit_npc     = e_pc[head] + cpu_pkg::xlen'(4);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			e_done       <= '0;
			error_status <= cpu_pkg::no_error;
		end else begin
			// pointers wrap on their own, depth is a power of two
			if (dispatch_valid) tail <= tail + 1'b1;
			if (commit_valid) head <= head + 1'b1;
			count <= count + (ptr_bits + 1)'(dispatch_valid) - (ptr_bits + 1)'(commit_valid);

			// illegal and wfi never see the alu
			if (dispatch_valid) e_done[tail] <= disp_illegal | disp_halt;
			if (cdb_valid) e_done[cdb_rob_idx] <= 1'b1;

			if (head_ready && head_error) begin
				if (e_illegal[head]) error_status <= cpu_pkg::illegal_inst;
				else error_status <= cpu_pkg::halted_on_wfi;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// entry payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (dispatch_valid) begin
			e_dest[tail]    <= disp_dest;
			e_pc[tail]      <= disp_pc;
			e_wr[tail]      <= disp_wr;
			e_illegal[tail] <= disp_illegal;
			e_halt[tail]    <= disp_halt;
		end
		// result lands with its rob index
		if (cdb_valid) e_data[cdb_rob_idx] <= cdb_data;
	end

endmodule

// ==== design/decode_stage.sv ====
// decode stage with register file and busy scoreboard, dispatches to rob and alu
`timescale 1ns/1ns

module decode_stage (
	input  logic                             clock,
	input  logic                             rst_n,
	input  logic [cpu_pkg::xlen-1:0]         inst,
	input  logic [cpu_pkg::xlen-1:0]         inst_pc,
	input  logic                             inst_valid,
	output logic                             dispatch_stall,
	input  logic                             rob_full,
	output logic                             dispatch_valid,
	output logic [cpu_pkg::reg_idx_bits-1:0] disp_dest,
	output logic                             disp_wr,
	output logic                             disp_illegal,
	output logic                             disp_halt,
	output logic [cpu_pkg::xlen-1:0]         disp_pc,
	output cpu_pkg::alu_op_e                 alu_op,
	output logic [cpu_pkg::xlen-1:0]         opa,
	output logic [cpu_pkg::xlen-1:0]         opb,
	input  logic                             commit_wr_en,
	input  logic [cpu_pkg::reg_idx_bits-1:0] commit_wr_idx,
	input  logic [cpu_pkg::xlen-1:0]         commit_wr_data
);

	localparam int nregs = 2 ** cpu_pkg::reg_idx_bits;

	// rv32 major opcodes in the subset
	localparam logic [6:0] rv_op     = 7'b0110011;
	localparam logic [6:0] rv_op_imm = 7'b0010011;
	localparam logic [6:0] rv_lui    = 7'b0110111;
	localparam logic [6:0] rv_system = 7'b1110011;
	localparam logic [31:0] wfi_word = 32'h10500073;

	logic [cpu_pkg::xlen-1:0]         regs [nregs];
	logic [nregs-1:0]                 busy;
	logic [cpu_pkg::reg_idx_bits-1:0] rs1;
	logic [cpu_pkg::reg_idx_bits-1:0] rs2;
	logic [cpu_pkg::xlen-1:0]         rs1_val;
	logic [cpu_pkg::xlen-1:0]         rs2_val;
	logic [cpu_pkg::xlen-1:0]         imm;
	logic                             use_imm;
	logic                             uses_rs1;
	logic                             uses_rs2;
	logic                             writes;
	logic                             hazard;

	assign rs1       = inst[19:15];
	assign rs2       = inst[24:20];
	assign disp_dest = inst[11:7];
	assign disp_pc   = inst_pc;

	////////////////////////////////////////////////////////////
	// instruction decode
	////////////////////////////////////////////////////////////

	always_comb begin
		alu_op       = cpu_pkg::op_add;
		imm          = '0;
		use_imm      = 1'b0;
		uses_rs1     = 1'b0;
		uses_rs2     = 1'b0;
		writes       = 1'b0;
		disp_illegal = 1'b0;
		disp_halt    = 1'b0;
		case (inst[6:0])
			rv_op: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				writes   = 1'b1;
				// funct7 and funct3 together
				case ({inst[31:25], inst[14:12]})
					{7'h00, 3'b000}: alu_op = cpu_pkg::op_add;
					{7'h20, 3'b000}: alu_op = cpu_pkg::op_sub;
					{7'h00, 3'b111}: alu_op = cpu_pkg::op_and;
					{7'h00, 3'b110}: alu_op = cpu_pkg::op_or;
					{7'h00, 3'b100}: alu_op = cpu_pkg::op_xor;
					default: begin
						writes       = 1'b0;
						disp_illegal = 1'b1;
					end
				endcase
			end
			rv_op_imm: begin
				// only addi
				if (inst[14:12] == 3'b000) begin
					uses_rs1 = 1'b1;
					writes   = 1'b1;
					use_imm  = 1'b1;
					imm      = {{20{inst[31]}}, inst[31:20]};
				end else begin
					disp_illegal = 1'b1;
				end
			end
			rv_lui: begin
				alu_op  = cpu_pkg::op_lui;
				writes  = 1'b1;
				use_imm = 1'b1;
				imm     = {inst[31:12], 12'b0};
			end
			rv_system: begin
				if (inst == wfi_word) disp_halt = 1'b1;
				else disp_illegal = 1'b1;
			end
			default: disp_illegal = 1'b1;
		endcase
	end

	// x0 writes travel but never set busy or commit
	assign disp_wr = writes && (disp_dest != '0);

	// x0 reads as zero
	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];
	assign opa     = rs1_val;
	assign opb     = use_imm ? imm : rs2_val;

	// raw on sources, plus waw on dest so an older commit cannot clear a younger busy bit
	assign hazard = (uses_rs1 && busy[rs1]) || (uses_rs2 && busy[rs2]) ||
		(disp_wr && busy[disp_dest]);

	assign dispatch_stall = inst_valid && (hazard || rob_full);
	assign dispatch_valid = inst_valid && !dispatch_stall;

	////////////////////////////////////////////////////////////
	// register file and scoreboard
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '{default: '0};
			busy <= '0;
		end else begin
			if (commit_wr_en) begin
				regs[commit_wr_idx] <= commit_wr_data;
				busy[commit_wr_idx] <= 1'b0;
			end
			// new writer wins over a same-cycle clear
			if (dispatch_valid && disp_wr) busy[disp_dest] <= 1'b1;
		end
	end

endmodule

// ==== design/fetch_stage.sv ====
// fetch stage, holds the pc and picks the instruction word out of the cache line
`timescale 1ns/1ns

module fetch_stage (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic [cpu_pkg::line_bits-1:0] line_data,
	input  logic                          line_valid,
	input  logic                          dispatch_stall,
	output logic [cpu_pkg::xlen-1:0]      fetch_addr,
	output logic [cpu_pkg::xlen-1:0]      inst,
	output logic [cpu_pkg::xlen-1:0]      inst_pc,
	output logic                          inst_valid
);

	logic [cpu_pkg::xlen-1:0] pc;
	logic                     consume;

	// word taken by decode this cycle
	assign consume = inst_valid && !dispatch_stall;

	// no branches, pc only steps by one word
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (consume) begin
			pc <= pc + cpu_pkg::xlen'(4);
		end
	end

	// cache is looked up with the live pc
	assign fetch_addr = pc;

	// pc bit 2 picks upper or lower half of the line
	assign inst       = pc[2] ? line_data[63:32] : line_data[31:0];
	assign inst_pc    = pc;
	assign inst_valid = line_valid;

endmodule

// ==== design/icache.sv ====
// instruction cache miss controller, fills lines over the tag/response memory bus
`timescale 1ns/1ns

module icache #(
	parameter int cache_lines = 32
) (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic [cpu_pkg::xlen-1:0]      fetch_addr,
	output logic [cpu_pkg::line_bits-1:0] line_data,
	output logic                          line_valid,
	output cpu_pkg::bus_cmd_e             mem_command,
	output logic [cpu_pkg::xlen-1:0]      mem_addr,
	input  logic [cpu_pkg::tag_bits-1:0]  mem_response,
	input  logic [cpu_pkg::tag_bits-1:0]  mem_tag,
	input  logic [cpu_pkg::line_bits-1:0] mem_data
);

	localparam int off_bits = $clog2(cpu_pkg::line_bits / 8);
	localparam int idx_bits = $clog2(cache_lines);
	localparam int tag_w    = cpu_pkg::xlen - off_bits - idx_bits;

	// idle -> req (retry until accepted) -> wait (for the tag) -> idle
	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_wait
	} state_e;

	state_e                       state;
	logic [idx_bits-1:0]          rd_idx;
	logic [idx_bits-1:0]          fill_idx;
	logic [tag_w-1:0]             rd_tag;
	logic [tag_w-1:0]             fill_tag;
	logic [cpu_pkg::tag_bits-1:0] pend_tag;
	logic                         rd_hit;
	logic                         fill_done;

	// address split
	assign rd_idx = fetch_addr[off_bits +: idx_bits];
	assign rd_tag = fetch_addr[cpu_pkg::xlen-1 -: tag_w];

	// returning beat belongs to our fill
	assign fill_done = (state == st_wait) && (mem_tag == pend_tag);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:
					if (!rd_hit) state <= st_req;
				st_req:
					if (mem_response != '0) state <= st_wait;
				st_wait:
					if (fill_done) state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	// fill address and accepted tag
	always_ff @(posedge clock) begin
		if (state == st_idle && !rd_hit) begin
			fill_idx <= rd_idx;
			fill_tag <= rd_tag;
		end
		if (state == st_req) pend_tag <= mem_response;
	end

	// request stays up every cycle until memory takes it
	assign mem_command = (state == st_req) ? cpu_pkg::bus_load : cpu_pkg::bus_none;
	assign mem_addr    = {fill_tag, fill_idx, {off_bits{1'b0}}};

	icache_mem #(
		.cache_lines(cache_lines)
	) icache_mem0 (
		.clock  (clock),
		.rst_n  (rst_n),
		.wr_en  (fill_done),
		.wr_idx (fill_idx),
		.wr_tag (fill_tag),
		.wr_data(mem_data),
		.rd_idx (rd_idx),
		.rd_tag (rd_tag),
		.rd_data(line_data),
		.rd_hit (rd_hit)
	);

	assign line_valid = rd_hit;

endmodule

// ==== design/icache_mem.sv ====
// tag, valid and data arrays of the direct-mapped instruction cache, used by icache
`timescale 1ns/1ns

module icache_mem #(
	parameter int cache_lines = 32
) (
	input  logic                                    clock,
	input  logic                                    rst_n,
	input  logic                                    wr_en,
	input  logic [$clog2(cache_lines)-1:0]          wr_idx,
	input  logic [cpu_pkg::xlen-4-$clog2(cache_lines):0] wr_tag,
	input  logic [cpu_pkg::line_bits-1:0]           wr_data,
	input  logic [$clog2(cache_lines)-1:0]          rd_idx,
	input  logic [cpu_pkg::xlen-4-$clog2(cache_lines):0] rd_tag,
	output logic [cpu_pkg::line_bits-1:0]           rd_data,
	output logic                                    rd_hit
);

	// tag keeps whatever is left above index and 8-byte offset
	localparam int tag_w = cpu_pkg::xlen - 3 - $clog2(cache_lines);

	logic [cpu_pkg::line_bits-1:0] data_arr [cache_lines];
	logic [tag_w-1:0]              tag_arr [cache_lines];
	logic [cache_lines-1:0]        valid_arr;

	// only the valid bits need clearing
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid_arr <= '0;
		end else if (wr_en) begin
			valid_arr[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			data_arr[wr_idx] <= wr_data;
			tag_arr[wr_idx]  <= wr_tag;
		end
	end

	// combinational lookup
	assign rd_data = data_arr[rd_idx];
	assign rd_hit  = valid_arr[rd_idx] && (tag_arr[rd_idx] == rd_tag);

endmodule

// ==== design/cpu_pkg.sv ====
// shared widths, bus commands and enums for the processor, referenced by scoped name
package cpu_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	// data and address width
	localparam int xlen = 32;

	// one cache line = one memory beat = two instructions
	localparam int line_bits = 64;

	// architectural register index
	localparam int reg_idx_bits = 5;

	// memory transaction tag, zero means refused
	localparam int tag_bits = 4;

	////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////

	// memory bus command
	typedef enum logic [1:0] {
		bus_none = 2'h0,
		bus_load = 2'h1
	} bus_cmd_e;

	// alu operation picked by decode
	typedef enum logic [2:0] {
		op_add = 3'h0,
		op_sub = 3'h1,
		op_and = 3'h2,
		op_or  = 3'h3,
		op_xor = 3'h4,
		op_lui = 3'h5
	} alu_op_e;

	// sticky status from the rob head
	typedef enum logic [1:0] {
		no_error      = 2'h0,
		illegal_inst  = 2'h1,
		halted_on_wfi = 2'h2
	} error_status_e;

endpackage
